// ==== files.f ====
+incdir+tests
logic/cdr_pkg.sv
logic/mm_pd.sv
logic/cdr_loop_filter.sv
logic/cdr_snapshot.sv
logic/mm_cdr_top.sv
tests/tb_mm_cdr.sv

// ==== logic/cdr_loop_filter.sv ====
`default_nettype none

module cdr_loop_filter import cdr_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        ext_rstb,
    input  wire logic signed [err_width-1:0] pd_err_i,
    input  wire logic                        ramp_clock_i,
    input  wire cdr_cfg_t                    cfg_i,
    output pi_bus_t                          pi_ctl_o,
    output logic                             freq_lvl_cross_o,
    output logic                             settled_o,
    output cdr_state_t                       state_o
);

    logic [settle_width-1:0] settle_cnt;
    logic                    ramp_clock_ff;
    logic                    ramp_clock_sync;

    logic signed [est_width-1:0] err_ext;
    logic signed [est_width-1:0] err_sel;

    logic signed [est_width-1:0] ramp_pls_q, ramp_pls_d;
    logic signed [est_width-1:0] ramp_neg_q, ramp_neg_d;
    logic signed [est_width-1:0] freq_q, freq_d, freq_upd, prev_freq_upd_q;
    logic signed [est_width:0]   freq_diff;

    logic signed [est_width-1:0] phase_q, phase_d, phase_upd, phase_clamped;
    logic signed [est_width:0]   phase_upd_w;
    logic signed [est_width:0]   clamp_max;
    logic signed [est_width:0]   clamp_min;

    pi_word_t pi_word_q;

    //////////////////////////////////////////////////////////////////////
    // settling counter and ramp clock sync
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            settle_cnt      <= '0;
            settled_o       <= 1'b0;
            ramp_clock_ff   <= 1'b0;
            ramp_clock_sync <= 1'b0;
        end else begin
            if (settle_cnt != settle_width'(wait_cycles - 1)) begin
                settle_cnt <= settle_cnt + 1'b1;
            end
            settled_o       <= (settle_cnt == settle_width'(wait_cycles - 1));
            ramp_clock_ff   <= ramp_clock_i;
            ramp_clock_sync <= ramp_clock_ff;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // accumulator updates
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // error is forced to zero until settled
        err_ext = pd_err_i;
        if (!settled_o) begin
            err_sel = '0;
        end else begin
            err_sel = cfg_i.invert ? -err_ext : err_ext;
        end

        // ramp halves, split by the raw ramp clock
        ramp_pls_d = ramp_pls_q + (ramp_clock_i ? (err_sel <<< cfg_i.kr) : '0);
        ramp_neg_d = ramp_neg_q + (ramp_clock_i ? '0 : (err_sel <<< cfg_i.kr));
        if (!cfg_i.en_ramp_est) begin
            ramp_pls_d = '0;
            ramp_neg_d = '0;
        end

        freq_upd  = (err_sel <<< cfg_i.ki) + (ramp_clock_sync ? ramp_pls_q : -ramp_neg_q);
        freq_d    = freq_q + (cfg_i.en_freq_est ? freq_upd : '0);
        freq_diff = freq_upd - prev_freq_upd_q;

        // proportional path plus frequency estimate
        phase_upd   = (err_sel <<< cfg_i.kp) + freq_q;
        phase_upd_w = phase_upd;
        clamp_max   = {1'b0, cfg_i.clamp_amt};
        clamp_min   = -clamp_max;

        phase_clamped = phase_upd;
        if (cfg_i.en_clamp) begin
            if (phase_upd_w > clamp_max) begin
                phase_clamped = clamp_max[est_width-1:0];
            end else if (phase_upd_w < clamp_min) begin
                phase_clamped = clamp_min[est_width-1:0];
            end
        end

        phase_d = phase_q + phase_clamped;
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            ramp_pls_q       <= '0;
            ramp_neg_q       <= '0;
            freq_q           <= '0;
            prev_freq_upd_q  <= '0;
            phase_q          <= '0;
            pi_word_q        <= '0;
            freq_lvl_cross_o <= 1'b0;
        end else begin
            ramp_pls_q       <= settled_o ? ramp_pls_d : '0;
            ramp_neg_q       <= settled_o ? ramp_neg_d : '0;
            freq_q           <= settled_o ? freq_d : '0;
            prev_freq_upd_q  <= settled_o ? freq_upd : '0;
            phase_q          <= settled_o ? phase_d : '0;
            // integer part of the phase, one cycle behind the accumulator
            pi_word_q        <= phase_q[est_shift +: n_pi];
            freq_lvl_cross_o <= (freq_diff > 0);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < n_out; k++) begin
            pi_ctl_o[k] = cfg_i.en_ext_pi_ctl ? cfg_i.ext_pi_ctl : pi_word_q;
        end
    end

    assign state_o.phase_est = pi_word_q;
    assign state_o.freq_est  = freq_q;
    assign state_o.ramp_est  = ramp_clock_sync ? ramp_pls_q : ramp_neg_q;

    // magnitude of a wrapped phase step
    function automatic logic [est_width:0] step_mag(input logic signed [est_width-1:0] v);
        logic signed [est_width:0] w;
        w = v;
        return (w < 0) ? -w : w;
    endfunction

    // nothing accumulates during settling
    a_hold_until_settled: assert property (
        @(posedge clk) disable iff (!ext_rstb)
        !settled_o |-> (phase_q == '0)
    );

    // the step taken by the phase accumulator respects the clamp
    a_clamp_bound: assert property (
        @(posedge clk) disable iff (!ext_rstb)
        (cfg_i.en_clamp && settled_o) |=>
            (step_mag(phase_q - $past(phase_q)) <= {1'b0, $past(cfg_i.clamp_amt)})
    );

endmodule

`default_nettype wire

// ==== logic/cdr_pkg.sv ====
package cdr_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // adc sample width and interleave factor
    localparam int n_adc = 8;
    localparam int n_ti  = 4;

    // phase interpolator control
    localparam int n_pi  = 9;
    localparam int n_out = 4;

    // fraction bits carried by the estimators
    localparam int est_shift = 4;
    localparam int est_width = n_adc + 2 + est_shift + 1;

    // phase detector output
    localparam int err_width = n_adc + 2;

    // pd sum before saturation, 4 terms plus offset
    localparam int pd_sum_width = err_width + 3;

    // settling period after reset
    localparam int wait_cycles  = 32;
    localparam int settle_width = $clog2(wait_cycles);

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic signed [n_adc-1:0] adc_sample_t;

    // one group of interleaved samples, index 0 is the oldest
    typedef adc_sample_t [n_ti-1:0] adc_group_t;

    typedef logic [n_pi-1:0] pi_word_t;
    typedef pi_word_t [n_out-1:0] pi_bus_t;

    // loop configuration
    typedef struct packed {
        logic [3:0]                   kp;
        logic [3:0]                   ki;
        logic [3:0]                   kr;
        logic                         invert;
        logic                         en_freq_est;
        logic                         en_ramp_est;
        logic                         en_clamp;
        logic [est_width-1:0]         clamp_amt;
        logic signed [err_width-1:0]  pd_offset;
        logic                         en_ext_pi_ctl;
        pi_word_t                     ext_pi_ctl;
    } cdr_cfg_t;

    // loop state as seen by the snapshot port
    typedef struct packed {
        pi_word_t             phase_est;
        logic [est_width-1:0] freq_est;
        logic [est_width-1:0] ramp_est;
    } cdr_state_t;

endpackage

// ==== logic/cdr_snapshot.sv ====
`default_nettype none

module cdr_snapshot import cdr_pkg::*; (
    input  wire logic       clk,
    input  wire logic       ext_rstb,
    input  wire cdr_state_t state_i,
    input  wire logic       snap_req_i,
    output logic            snap_ack_o,
    output cdr_state_t      snap_state_o
);

    typedef enum logic [1:0] {
        SNAP_IDLE,
        SNAP_ACK,
        SNAP_RELEASE
    } snap_fsm_t;

    snap_fsm_t fsm_q;
    logic      capture;

    // take a copy only when a fresh request is seen in idle
    assign capture = (fsm_q == SNAP_IDLE) && snap_req_i;

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            fsm_q      <= SNAP_IDLE;
            snap_ack_o <= 1'b0;
        end else begin
            case (fsm_q)
                SNAP_IDLE: begin
                    if (snap_req_i) begin
                        fsm_q      <= SNAP_ACK;
                        snap_ack_o <= 1'b1;
                    end
                end
                SNAP_ACK: begin
                    // hold ack until the requester lets go
                    if (!snap_req_i) begin
                        fsm_q      <= SNAP_RELEASE;
                        snap_ack_o <= 1'b0;
                    end
                end
                default: begin
                    fsm_q <= SNAP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            snap_state_o <= state_i;
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!ext_rstb)
        $rose(snap_ack_o) |-> $past(snap_req_i)
    );

    a_copy_frozen: assert property (
        @(posedge clk) disable iff (!ext_rstb)
        snap_ack_o |=> $stable(snap_state_o)
    );

endmodule

`default_nettype wire

// ==== logic/mm_cdr_top.sv ====
`default_nettype none

module mm_cdr_top import cdr_pkg::*; (
    input  wire logic       clk,
    input  wire logic       ext_rstb,
    input  wire adc_group_t din_i,
    input  wire logic       ramp_clock_i,
    input  wire cdr_cfg_t   cfg_i,
    input  wire logic       snap_req_i,
    output pi_bus_t         pi_ctl_o,
    output logic            freq_lvl_cross_o,
    output logic            settled_o,
    output logic            snap_ack_o,
    output cdr_state_t      snap_state_o
);

    logic signed [err_width-1:0] pd_err;
    cdr_state_t                  loop_state;

    // phase detector
    mm_pd u_mm_pd (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .din_i       (din_i),
        .pd_offset_i (cfg_i.pd_offset),
        .pd_err_o    (pd_err)
    );

    // second order loop filter
    cdr_loop_filter u_loop_filter (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .pd_err_i         (pd_err),
        .ramp_clock_i     (ramp_clock_i),
        .cfg_i            (cfg_i),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .settled_o        (settled_o),
        .state_o          (loop_state)
    );

    // state readback
    cdr_snapshot u_snapshot (
        .clk          (clk),
        .ext_rstb     (ext_rstb),
        .state_i      (loop_state),
        .snap_req_i   (snap_req_i),
        .snap_ack_o   (snap_ack_o),
        .snap_state_o (snap_state_o)
    );

endmodule

`default_nettype wire

// ==== logic/mm_pd.sv ====
`default_nettype none

module mm_pd import cdr_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        ext_rstb,
    input  wire adc_group_t                  din_i,
    input  wire logic signed [err_width-1:0] pd_offset_i,
    output logic signed [err_width-1:0]      pd_err_o
);

    // mm term: cur * sgn(prev) - prev * sgn(cur)
    function automatic logic signed [n_adc+1:0] mm_term(
        input adc_sample_t cur,
        input adc_sample_t prev
    );
        logic signed [n_adc+1:0] c_ext;
        logic signed [n_adc+1:0] p_ext;
        c_ext = cur;
        p_ext = prev;
        return (prev[n_adc-1] ? -c_ext : c_ext) - (cur[n_adc-1] ? -p_ext : p_ext);
    endfunction

    adc_sample_t                    last_q;
    adc_group_t                     prev_grp;
    logic signed [pd_sum_width-1:0] sum;
    logic signed [err_width-1:0]    sat;

    always_comb begin
        // previous neighbour of each sample, wrapping to the last group
        prev_grp = {din_i[n_ti-2:0], last_q};

        sum = pd_offset_i;
        for (int i = 0; i < n_ti; i++) begin
            sum = sum + mm_term(din_i[i], prev_grp[i]);
        end

        // saturate when the upper bits are not a pure sign extension
        if ((&sum[pd_sum_width-1:err_width-1]) || !(|sum[pd_sum_width-1:err_width-1])) begin
            sat = sum[err_width-1:0];
        end else if (sum[pd_sum_width-1]) begin
            sat = {1'b1, {(err_width-1){1'b0}}};
        end else begin
            sat = {1'b0, {(err_width-1){1'b1}}};
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            pd_err_o <= '0;
            last_q   <= '0;
        end else begin
            pd_err_o <= sat;
            last_q   <= din_i[n_ti-1];
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build with verilator, then look for the pass line in the simulation output
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_mm_cdr -f files.f -o tb_mm_cdr \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_mm_cdr | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/cdr_tb_tasks.svh ====
//////////////////////////////////////////////////////////////////////
// stimulus and reference helpers
//////////////////////////////////////////////////////////////////////

// frequency estimate left behind by the second order test
logic [est_width-1:0] freq_exp = '0;

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken
task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        v      = {v[30:0], lfsr_q[0]};
    end
endtask

task automatic random_group(output adc_group_t g);
    logic [31:0] v;
    draw_bits(n_adc * n_ti, v);
    g = adc_group_t'(v);
endtask

function automatic adc_group_t make_group(input int s0, input int s1, input int s2, input int s3);
    adc_group_t g;
    g[0] = adc_sample_t'(s0);
    g[1] = adc_sample_t'(s1);
    g[2] = adc_sample_t'(s2);
    g[3] = adc_sample_t'(s3);
    return g;
endfunction

// mm error of a repeating group where sample 0 follows the last one
function automatic int mm_error(input adc_group_t g, input int offset);
    adc_sample_t cur;
    adc_sample_t prev;
    int          sum;
    sum = offset;
    for (int i = 0; i < n_ti; i++) begin
        cur  = g[i];
        prev = g[(i + n_ti - 1) % n_ti];
        sum  = sum + cur * (prev < 0 ? -1 : 1) - prev * (cur < 0 ? -1 : 1);
    end
    if (sum > (1 << (err_width - 1)) - 1) begin
        sum = (1 << (err_width - 1)) - 1;
    end else if (sum < -(1 << (err_width - 1))) begin
        sum = -(1 << (err_width - 1));
    end
    return sum;
endfunction

// pi step for an error through a gain shift modulo the control word
function automatic pi_word_t expected_step(input int e, input int k);
    return pi_word_t'((e <<< k) / (1 << est_shift));
endfunction

// state captured on the cycle req is first seen
function automatic cdr_state_t expected_snapshot();
    cdr_state_t s;
    s.phase_est = pi_log[pi_log.size() - 1];
    s.freq_est  = freq_exp;
    // ramp estimation stays off in every test
    s.ramp_est  = '0;
    return s;
endfunction

task automatic log_pi(input int n);
    pi_log.delete();
    repeat (n) begin
        @(negedge clk);
        pi_log.push_back(pi_ctl[0]);
    end
endtask

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_pi(input string name, input pi_word_t exp, input pi_word_t act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic check_state(input string name, input cdr_state_t exp, input cdr_state_t act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic all_pi_equal(input string name, input pi_word_t exp);
    for (int k = 0; k < n_out; k++) begin
        check_pi(name, exp, pi_ctl[k]);
    end
endtask

task automatic steps_match(input string name, input pi_word_t step);
    for (int i = 1; i < pi_log.size(); i++) begin
        check_pi(name, step, pi_word_t'(pi_log[i] - pi_log[i-1]));
    end
endtask

// second difference of the logged words
task automatic growth_matches(input string name, input pi_word_t growth);
    for (int i = 2; i < pi_log.size(); i++) begin
        check_pi(name, growth,
                 pi_word_t'((pi_log[i] - pi_log[i-1]) - (pi_log[i-1] - pi_log[i-2])));
    end
endtask

// raise req and log pi_ctl_o until ack shows up
task automatic request_snapshot();
    snap_req = 1'b1;
    pi_log.delete();
    pi_log.push_back(pi_ctl[0]);
    @(negedge clk);
    while (!snap_ack) begin
        pi_log.push_back(pi_ctl[0]);
        @(negedge clk);
    end
endtask

task automatic snapshot_seen_on_bus(input string name);
    bit seen;
    seen = 1'b0;
    foreach (pi_log[i]) begin
        if (pi_log[i] == snap_state.phase_est) begin
            seen = 1'b1;
        end
    end
    if (!seen) begin
        errors++;
        $display("%s: captured phase %0d never appeared on pi_ctl_o during the request",
                 name, snap_state.phase_est);
    end
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic settle_after_reset();
    adc_group_t g;
    for (int n = 1; n <= wait_cycles + 2; n++) begin
        random_group(g);
        din = g;
        @(negedge clk);
        check_bit("settled timing", n >= wait_cycles, settled);
        if (n <= wait_cycles) begin
            all_pi_equal("pi during settling", '0);
        end
    end
endtask

task automatic override_follows_ext();
    logic [31:0] v;
    for (int i = 0; i < 8; i++) begin
        draw_bits(n_pi, v);
        cfg.en_ext_pi_ctl = 1'b1;
        cfg.ext_pi_ctl    = pi_word_t'(v);
        #1;
        all_pi_equal("override", pi_word_t'(v));
        @(negedge clk);
    end
    cfg.en_ext_pi_ctl = 1'b0;
endtask

task automatic first_order_steps();
    adc_group_t pat;
    adc_group_t zero;
    pat  = make_group(10, 20, 30, -5);
    zero = make_group(0, 0, 0, 0);
    din  = pat;
    cfg.kp          = 4'd2;
    cfg.en_freq_est = 1'b0;
    cfg.en_ramp_est = 1'b0;
    cfg.en_clamp    = 1'b0;
    cfg.pd_offset   = '0;
    repeat (4) @(negedge clk);
    log_pi(4);
    steps_match("loop step", expected_step(mm_error(pat, 0), 2));
    cfg.invert = 1'b1;
    repeat (4) @(negedge clk);
    log_pi(4);
    steps_match("inverted step", expected_step(-mm_error(pat, 0), 2));
    cfg.invert = 1'b0;
    din        = zero;
    repeat (4) @(negedge clk);
    log_pi(4);
    steps_match("zero step", expected_step(mm_error(zero, 0), 2));
endtask

task automatic clamp_limits_step();
    int clamp;
    clamp         = 64;
    din           = make_group(10, 20, 30, -5);
    cfg.en_clamp  = 1'b1;
    cfg.clamp_amt = est_width'(clamp);
    repeat (4) @(negedge clk);
    log_pi(4);
    steps_match("clamped step", pi_word_t'(clamp / (1 << est_shift)));
    cfg.en_clamp = 1'b0;
endtask

task automatic second_order_growth();
    adc_group_t pat;
    int         e;
    int         e_hi;
    pat             = make_group(10, 20, 30, -5);
    e               = mm_error(pat, 0);
    e_hi            = mm_error(pat, 16);
    din             = pat;
    cfg.ki          = 4'd2;
    cfg.en_freq_est = 1'b1;
    repeat (4) @(negedge clk);
    log_pi(5);
    growth_matches("freq growth", expected_step(e, 2));
    check_bit("level cross steady", 1'b0, freq_lvl_cross);
    // larger error from here on
    cfg.pd_offset = err_width'(16);
    @(negedge clk);
    check_bit("level cross before", 1'b0, freq_lvl_cross);
    @(negedge clk);
    check_bit("level cross after rise", 1'b1, freq_lvl_cross);
    cfg.en_freq_est = 1'b0;
    cfg.pd_offset   = '0;
    // ten updates at e and one at the raised error
    freq_exp = est_width'(10 * (e <<< 2) + (e_hi <<< 2));
endtask

task automatic snapshot_handshake();
    cdr_state_t exp_state;
    pi_word_t   first_phase;
    request_snapshot();
    snapshot_seen_on_bus("first snapshot");
    exp_state = expected_snapshot();
    check_state("first snapshot", exp_state, snap_state);
    first_phase = exp_state.phase_est;
    repeat (5) begin
        @(negedge clk);
        check_bit("ack held", 1'b1, snap_ack);
        check_state("snapshot frozen", exp_state, snap_state);
    end
    snap_req = 1'b0;
    @(negedge clk);
    check_bit("ack release", 1'b0, snap_ack);
    request_snapshot();
    snapshot_seen_on_bus("second snapshot");
    check_state("second snapshot", expected_snapshot(), snap_state);
    if (snap_state.phase_est == first_phase) begin
        errors++;
        $display("second snapshot returned the same phase as the first one");
    end
    snap_req = 1'b0;
    @(negedge clk);
    check_bit("second ack release", 1'b0, snap_ack);
endtask

// ==== tests/tb_mm_cdr.sv ====
module tb_mm_cdr import cdr_pkg::*; ();

    localparam int clk_half     = 5;
    localparam int reset_cycles = 5;

    // rough length of each directed test in cycles
    localparam int len_settle   = 40;
    localparam int len_override = 10;
    localparam int len_loop     = 30;
    localparam int len_clamp    = 10;
    localparam int len_freq     = 15;
    localparam int len_snap     = 25;
    localparam int timeout_cycles = reset_cycles + len_settle + len_override + len_loop
                                  + len_clamp + len_freq + len_snap + 200;

    logic       clk;
    logic       ext_rstb;
    adc_group_t din;
    logic       ramp_clock;
    cdr_cfg_t   cfg;
    logic       snap_req;
    pi_bus_t    pi_ctl;
    logic       freq_lvl_cross;
    logic       settled;
    logic       snap_ack;
    cdr_state_t snap_state;

    int          errors    = 0;
    int          cycle_cnt = 0;
    logic [31:0] lfsr_q;
    pi_word_t    pi_log[$];

    mm_cdr_top DUT (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .din_i            (din),
        .ramp_clock_i     (ramp_clock),
        .cfg_i            (cfg),
        .snap_req_i       (snap_req),
        .pi_ctl_o         (pi_ctl),
        .freq_lvl_cross_o (freq_lvl_cross),
        .settled_o        (settled),
        .snap_ack_o       (snap_ack),
        .snap_state_o     (snap_state)
    );

    `include "cdr_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles) begin
            $display("timeout after %0d cycles, errors: %0d", cycle_cnt, errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        ext_rstb   = 1'b0;
        din        = '0;
        ramp_clock = 1'b0;
        cfg        = '0;
        snap_req   = 1'b0;
        lfsr_q     = 32'h4f7e_76d9;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        check_bit("reset settled", 1'b0, settled);
        all_pi_equal("reset pi", '0);
        ext_rstb = 1'b1;

        settle_after_reset();
        override_follows_ext();
        first_order_steps();
        clamp_limits_step();
        second_order_growth();
        snapshot_handshake();

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
